// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

   // ----------------------------------------
   // Widths
   // ----------------------------------------
   localparam int ADDR_W = 32;             // Linear address
   localparam int DATA_W = 32;             // One dword beat from memory
   localparam int LEN_W  = 5;              // Fetch length, 0 to 16 bytes
   localparam int CNT_W  = 3;              // Byte count of one beat, 0 to 4
   localparam int OFF_W  = 2;              // Byte offset inside a dword

   // ----------------------------------------
   // Beat constants
   // ----------------------------------------
   localparam int BEATS          = 4;      // Dwords per 16-byte line
   localparam int BYTES_PER_BEAT = 4;      // Bytes in one dword

   // Request as the front end presents it
   // Length is already clipped at page and segment limits
   typedef struct packed {
      logic [ADDR_W-1:0] address;
      logic [LEN_W-1:0]  length;
   } fetch_req_t;                          // 37 bits

   // Per-beat byte counts of the read in flight
   // Element 0 is the beat the memory returns next
   typedef struct packed {
      logic [BEATS-1:0][CNT_W-1:0] cnt;
   } beat_plan_t;                          // 12 bits

   // One prefetch queue entry
   typedef struct packed {
      logic [DATA_W-1:0] data;             // Aligned to byte 0, unused bytes zero
      logic [CNT_W-1:0]  count;            // Valid bytes
   } prefetch_entry_t;                     // 35 bits

endpackage

// ==== rtl/beat_planner.sv ====
`timescale 1ns/1ps

// Keeps the byte count of every beat of the current line read.
// Loaded at acceptance, shifted down one element per counted beat.
module beat_planner import fetch_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             load,      // Request accepted this cycle
   input  logic             advance,   // Current beat consumed
   input  fetch_req_t       req,
   output logic [CNT_W-1:0] count      // Count of the current beat
);

   // ----------------------------------------
   // Plan register and next value
   // ----------------------------------------
   beat_plan_t plan;
   beat_plan_t plan_next;

   logic [OFF_W-1:0] byte_off;          // Offset of first byte in its dword
   logic [1:0]       dword_idx;         // Dword of the request inside the line

   assign byte_off  = req.address[OFF_W-1:0];
   assign dword_idx = req.address[OFF_W+1:OFF_W];

   always_comb begin
      plan_next = plan;                 // Hold by default
      if (load) begin
         // First beat only carries the bytes from the offset upward
         plan_next.cnt[0] = CNT_W'(BYTES_PER_BEAT) - CNT_W'(byte_off);
         // Full dwords until the line ends and nothing after it
         for (int i = 1; i < BEATS; i++) begin
            if (int'(dword_idx) + i < BEATS) begin
               plan_next.cnt[i] = CNT_W'(BYTES_PER_BEAT);
            end else begin
               plan_next.cnt[i] = '0;
            end
         end
      end else if (advance) begin
         // Drop the beat just used and fill the top with zero
         plan_next.cnt = {{CNT_W{1'b0}}, plan.cnt[BEATS-1:1]};
      end
   end

   // ----------------------------------------
   // State
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         plan <= '0;                    // No read in flight
      end else begin
         plan <= plan_next;
      end
   end

   // Bottom element belongs to the beat the memory returns next
   assign count = plan.cnt[0];

endmodule

// ==== rtl/beat_aligner.sv ====
`timescale 1ns/1ps

// Moves the first useful byte of a returned dword down to byte 0
// and clears every byte the entry does not own
module beat_aligner import fetch_pkg::*; (
   input  logic [DATA_W-1:0] raw,       // Dword as memory returned it
   input  logic [OFF_W-1:0]  offset,    // Byte offset, only nonzero on beat 0
   input  logic [CNT_W-1:0]  count,     // Bytes kept from byte 0 upward
   output logic [DATA_W-1:0] data
);

   // ----------------------------------------
   // Byte shift
   // ----------------------------------------
   logic [DATA_W-1:0]  shifted;
   logic [OFF_W+2:0]   shift_bits;      // Offset in bits, 0 to 24

   assign shift_bits = {offset, 3'b000};
   assign shifted    = raw >> shift_bits;

   // ----------------------------------------
   // Byte mask
   // ----------------------------------------
   always_comb begin
      for (int b = 0; b < BYTES_PER_BEAT; b++) begin
         if (b < int'(count)) begin
            data[8*b +: 8] = shifted[8*b +: 8];   // Owned byte
         end else begin
            data[8*b +: 8] = 8'h00;               // Past the count
         end
      end
   end

   // Count comes from the sequencer as min(plan, remaining);
   // anything above a dword means the plan or the length got corrupted
   always_comb begin
      if (!$isunknown(count)) begin
         assert (int'(count) <= BYTES_PER_BEAT)
            else $error("beat_aligner: count %0d above dword size", count);
      end
   end

   // A shifted-out byte would be lost silently, so the offset plus
   // the kept bytes must stay inside the dword
   always_comb begin
      if (!$isunknown({offset, count}) && count != '0) begin
         assert (int'(offset) + int'(count) <= BYTES_PER_BEAT)
            else $error("beat_aligner: offset %0d with count %0d", offset, count);
      end
   end

endmodule

// ==== rtl/fetch_sequencer.sv ====
`timescale 1ns/1ps

// Idle/read FSM of the code fetch path.
// Accepts one request, issues the line read, turns each returned beat
// into a prefetch entry and reports the consumed length.
module fetch_sequencer import fetch_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              pr_reset,              // Pipeline flush
   input  logic              fetch_do,
   input  fetch_req_t        fetch_req,
   input  logic              readcode_done,         // Last beat
   input  logic              readcode_partial_done, // Every other beat
   input  logic [CNT_W-1:0]  plan_count,
   input  logic [DATA_W-1:0] aligned_data,
   output logic              readcode_do,
   output logic [ADDR_W-1:0] readcode_address,
   output logic              plan_load,
   output logic              plan_advance,
   output logic [OFF_W-1:0]  align_offset,
   output logic [CNT_W-1:0]  align_count,
   output logic              prefetch_write_do,
   output prefetch_entry_t   prefetch_entry,
   output logic              prefetched_do,
   output logic [LEN_W-1:0]  prefetched_length
);

   typedef enum logic {
      ST_IDLE,
      ST_READ
   } state_t;

   // ----------------------------------------
   // Registers
   // ----------------------------------------
   state_t           state;
   logic [LEN_W-1:0] remaining;     // Bytes still owed to the queue
   logic             first_beat;    // Next beat is beat 0 of the line
   logic             reset_waiting; // Flushed, draining the rest of the read
   logic [OFF_W-1:0] req_offset;    // Byte offset of the accepted request

   // ----------------------------------------
   // Decode
   // ----------------------------------------
   logic             accept;
   logic             beat;
   logic             flush;
   logic [LEN_W-1:0] plan_len;
   logic [LEN_W-1:0] entry_len;
   logic [CNT_W-1:0] entry_count;
   logic             counted;

   assign accept = (state == ST_IDLE) && fetch_do && !pr_reset
                   && (fetch_req.length != '0);
   assign beat   = (state == ST_READ) && (readcode_partial_done || readcode_done);
   assign flush  = pr_reset || reset_waiting;      // Current and later beats dropped

   // Smaller of planned count and what is left of the request
   assign plan_len    = LEN_W'(plan_count);
   assign entry_len   = (plan_len > remaining) ? remaining : plan_len;
   assign entry_count = entry_len[CNT_W-1:0];      // Never above 4

   assign counted = beat && !flush && (entry_count != '0);

   // Read request, same cycle as acceptance
   assign readcode_do      = accept;
   assign readcode_address = {fetch_req.address[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

   // Planner and aligner control
   assign plan_load    = accept;
   assign plan_advance = counted;
   assign align_offset = first_beat ? req_offset : '0;
   assign align_count  = entry_count;

   // Entry toward the prefetch queue
   assign prefetch_entry.data  = aligned_data;
   assign prefetch_entry.count = entry_count;
   assign prefetch_write_do    = counted;
   assign prefetched_do        = counted;
   assign prefetched_length    = entry_len;

   // ----------------------------------------
   // FSM and length bookkeeping
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         remaining  <= '0;
         first_beat <= 1'b0;
      end else if (accept) begin
         state      <= ST_READ;
         remaining  <= fetch_req.length;
         first_beat <= 1'b1;
      end else if (state == ST_READ) begin
         if (counted) remaining <= remaining - entry_len;
         if (beat) first_beat <= 1'b0;        // Offset only applies once
         if (readcode_done) state <= ST_IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         reset_waiting <= 1'b0;
      end else if (pr_reset && state != ST_IDLE) begin
         reset_waiting <= 1'b1;
      end else if (state == ST_IDLE) begin
         reset_waiting <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) req_offset <= fetch_req.address[OFF_W-1:0];
   end

   // Memory only answers a read that was issued
   a_no_beat_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (state == ST_IDLE) |-> !(readcode_partial_done || readcode_done))
      else $error("fetch_sequencer: beat strobe while idle");

   // One strobe per beat
   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      !(readcode_partial_done && readcode_done))
      else $error("fetch_sequencer: partial and final beat together");

endmodule

// ==== rtl/code_fetch_top.sv ====
`timescale 1ns/1ps

// Uncached code fetch path: one line read per request, one
// prefetch entry per returned dword
module code_fetch_top import fetch_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              pr_reset,
   input  logic              fetch_do,
   input  fetch_req_t        fetch_req,
   input  logic              readcode_done,
   input  logic              readcode_partial_done,
   input  logic [DATA_W-1:0] readcode_partial,
   output logic              readcode_do,
   output logic [ADDR_W-1:0] readcode_address,
   output logic              prefetch_write_do,
   output prefetch_entry_t   prefetch_entry,
   output logic              prefetched_do,
   output logic [LEN_W-1:0]  prefetched_length
);

   // ----------------------------------------
   // Internal wires
   // ----------------------------------------
   logic              plan_load;
   logic              plan_advance;
   logic [CNT_W-1:0]  plan_count;
   logic [OFF_W-1:0]  align_offset;
   logic [CNT_W-1:0]  align_count;
   logic [DATA_W-1:0] aligned_data;

   beat_planner u_planner (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (plan_load),
      .advance (plan_advance),
      .req     (fetch_req),
      .count   (plan_count)
   );

   beat_aligner u_aligner (
      .raw    (readcode_partial),   // Same bus for every beat
      .offset (align_offset),
      .count  (align_count),
      .data   (aligned_data)
   );

   fetch_sequencer u_sequencer (
      .clk                   (clk),
      .rst_n                 (rst_n),
      .pr_reset              (pr_reset),
      .fetch_do              (fetch_do),
      .fetch_req             (fetch_req),
      .readcode_done         (readcode_done),
      .readcode_partial_done (readcode_partial_done),
      .plan_count            (plan_count),
      .aligned_data          (aligned_data),
      .readcode_do           (readcode_do),
      .readcode_address      (readcode_address),
      .plan_load             (plan_load),
      .plan_advance          (plan_advance),
      .align_offset          (align_offset),
      .align_count           (align_count),
      .prefetch_write_do     (prefetch_write_do),
      .prefetch_entry        (prefetch_entry),
      .prefetched_do         (prefetched_do),
      .prefetched_length     (prefetched_length)
   );

endmodule

// ==== tests/fetch_cases.svh ====
`ifndef FETCH_CASES_SVH
`define FETCH_CASES_SVH

// ----------------------------------------
// Directed fetch cases
// ----------------------------------------
// Columns: address, length, flush_req, flush_beat, writes
//   flush_req   pr_reset held high together with fetch_do
//   flush_beat  beat 1 to 4 that sees pr_reset, 0 for none
//   writes      prefetch writes the request should produce

typedef struct packed {
   logic [ADDR_W-1:0] address;
   logic [LEN_W-1:0]  length;
   logic              flush_req;
   logic [2:0]        flush_beat;
   logic [2:0]        writes;
} fetch_case_t;                            // 44 bits

fetch_case_t case_table [14] = '{
   // Aligned full line, four dwords
   {32'h0000_1000, 5'd16, 1'b0, 3'd0, 3'd4},
   // Offset 3, one byte then full dwords
   {32'h0000_2003, 5'd13, 1'b0, 3'd0, 3'd4},
   // Short request, 3 then 2 bytes
   {32'h0000_3001, 5'd5,  1'b0, 3'd0, 3'd2},
   // Zero length is ignored
   {32'h0000_4000, 5'd0,  1'b0, 3'd0, 3'd0},
   // Presented during a pipeline reset
   {32'h0000_5000, 5'd8,  1'b1, 3'd0, 3'd0},
   // Flush on the second beat
   {32'h0000_6000, 5'd16, 1'b0, 3'd2, 3'd1},
   {32'h0000_7004, 5'd8,  1'b0, 3'd0, 3'd2},   // Right after the flush
   {32'h0000_800a, 5'd6,  1'b0, 3'd0, 3'd2},
   {32'h0000_900d, 5'd3,  1'b0, 3'd0, 3'd1},   // Last dword of the line
   {32'h0000_a00f, 5'd1,  1'b0, 3'd0, 3'd1},   // Single top byte
   {32'h0000_b000, 5'd16, 1'b0, 3'd1, 3'd0},   // Flush on first beat
   {32'h0000_c0f6, 5'd10, 1'b0, 3'd3, 3'd2},
   {32'h0000_d000, 5'd16, 1'b0, 3'd4, 3'd3},   // Flush with the final beat
   {32'hffff_fff0, 5'd16, 1'b0, 3'd0, 3'd4}    // Top of the address space
};

`endif

// ==== tests/tb_code_fetch.sv ====
`timescale 1ns/1ps

module tb_code_fetch import fetch_pkg::*; ();

   // ----------------------------------------
   // DUT signals
   // ----------------------------------------
   logic              clk;
   logic              rst_n;
   logic              pr_reset;
   logic              fetch_do;
   fetch_req_t        fetch_req;
   logic              readcode_done;
   logic              readcode_partial_done;
   logic [DATA_W-1:0] readcode_partial;
   logic              readcode_do;
   logic [ADDR_W-1:0] readcode_address;
   logic              prefetch_write_do;
   prefetch_entry_t   prefetch_entry;
   logic              prefetched_do;
   logic [LEN_W-1:0]  prefetched_length;

   `include "fetch_cases.svh"

   prefetch_entry_t   seen_entry [$];      // Writes of the current fetch
   logic [LEN_W-1:0]  seen_len [$];
   logic [1:0]        seen_strobe [$];     // {prefetch_write_do, prefetched_do} per write
   int                read_reqs;           // readcode_do pulses of the current fetch
   int                err_count;
   integer            seed;

   code_fetch_top uut (.*);

   always #2 clk = ~clk;                   // 4 ns period

   // ----------------------------------------
   // Checking helpers
   // ----------------------------------------
   task automatic abort_run(input string msg);
      err_count++;
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
                             $time, what, got, exp));
      end
   endtask

   // Bytes of beat j from the request offset and dword position
   function automatic int planned_bytes(input logic [ADDR_W-1:0] addr, input int j);
      int n;
      n = 0;
      if (j == 0) begin
         n = 4 - int'(addr[1:0]);          // From the offset up
      end else if (int'(addr[3:2]) + j < BEATS) begin
         n = 4;                            // Full dword inside the line
      end
      return n;
   endfunction

   // Byte k of the line holds its low address byte plus k
   function automatic logic [DATA_W-1:0] line_dword(input logic [ADDR_W-1:0] base, input int j);
      logic [DATA_W-1:0] w;
      for (int b = 0; b < 4; b++) begin
         w[8*b +: 8] = base[7:0] + 8'(4 * j + b);
      end
      return w;
   endfunction

   function automatic logic [DATA_W-1:0] expected_data(input logic [ADDR_W-1:0] addr,
                                                       input int j, input int cnt);
      logic [DATA_W-1:0] d;
      logic [7:0]        first;            // Value of the first kept byte
      d     = '0;
      first = {addr[7:2], 2'b00} + 8'(4 * j);
      if (j == 0) begin
         first = first + {6'd0, addr[1:0]};
      end
      for (int b = 0; b < cnt; b++) begin
         d[8*b +: 8] = first + 8'(b);
      end
      return d;
   endfunction

   // Write monitor samples mid-cycle once outputs have settled
   always @(negedge clk) begin
      if (rst_n) begin
         if (prefetch_write_do || prefetched_do) begin
            seen_entry.push_back(prefetch_entry);
            seen_len.push_back(prefetched_length);
            seen_strobe.push_back({prefetch_write_do, prefetched_do});
         end
         if (readcode_do) begin
            read_reqs++;
         end
      end
   end

   // ----------------------------------------
   // Memory responder sends four beats one idle cycle apart
   // ----------------------------------------
   task automatic serve_line(input logic [ADDR_W-1:0] base, input int flush_beat);
      for (int j = 0; j < BEATS; j++) begin
         @(posedge clk);
         #1;
         readcode_partial      = line_dword(base, j);
         readcode_partial_done = (j < BEATS - 1);
         readcode_done         = (j == BEATS - 1);   // Final beat
         pr_reset              = (flush_beat == j + 1);
         @(posedge clk);
         #1;
         readcode_partial      = '0;
         readcode_partial_done = 1'b0;
         readcode_done         = 1'b0;
         pr_reset              = 1'b0;
      end
   endtask

   task automatic run_case(input fetch_case_t tc, input bit use_writes, output int sum);
      prefetch_entry_t   exp_q [$];
      prefetch_entry_t   e;
      int                remaining;
      int                c;
      bit                accepted;
      bit                got_read;
      logic [ADDR_W-1:0] line_addr;

      accepted  = (tc.length != '0) && !tc.flush_req;
      remaining = int'(tc.length);
      for (int j = 0; j < BEATS && accepted; j++) begin
         c = planned_bytes(tc.address, j);
         if (c > remaining) begin
            c = remaining;                 // Length runs out first
         end
         if (c != 0 && !(tc.flush_beat != 0 && j + 1 >= int'(tc.flush_beat))) begin
            e.count = CNT_W'(c);
            e.data  = expected_data(tc.address, j, c);
            exp_q.push_back(e);
         end
         remaining = remaining - c;
      end
      if (use_writes) begin
         compare(64'(exp_q.size()), 64'(tc.writes), "table write count against rule");
      end

      @(posedge clk);
      #1;
      seen_entry.delete();
      seen_len.delete();
      seen_strobe.delete();
      read_reqs         = 0;
      fetch_req.address = tc.address;
      fetch_req.length  = tc.length;
      fetch_do          = 1'b1;
      pr_reset          = tc.flush_req;
      if (accepted) begin
         got_read = 1'b0;
         for (int w = 0; w < 8 && !got_read; w++) begin
            @(negedge clk);
            got_read = readcode_do;
         end
         if (!got_read) begin
            abort_run($sformatf("No read request for the fetch at 0x%08h", tc.address));
         end
         line_addr = readcode_address;
         compare(64'(line_addr), 64'({tc.address[ADDR_W-1:2], 2'b00}), "readcode_address");
         @(posedge clk);
         #1;
         fetch_do = 1'b0;
         serve_line(line_addr, int'(tc.flush_beat));
      end else begin
         @(posedge clk);
         #1;
         fetch_do = 1'b0;
         pr_reset = 1'b0;
         repeat (4) @(posedge clk);        // Quiet window where nothing may start
         #1;
      end
      compare(64'(read_reqs), accepted ? 64'd1 : 64'd0, "read requests per fetch");

      if (seen_entry.size() < exp_q.size()) begin
         abort_run($sformatf("Missing prefetch write for 0x%08h: %0d of %0d seen",
                             tc.address, seen_entry.size(), exp_q.size()));
      end
      if (seen_entry.size() > exp_q.size()) begin
         abort_run($sformatf("Extra prefetch write for 0x%08h: %0d seen, %0d expected",
                             tc.address, seen_entry.size(), exp_q.size()));
      end
      sum = 0;
      foreach (exp_q[k]) begin
         // Both strobes pulse together for every entry
         compare(64'(seen_strobe[k]), 64'(2'b11), "write and prefetched strobes");
         compare(64'(seen_entry[k].count), 64'(exp_q[k].count), "entry count");
         compare(64'(seen_entry[k].data), 64'(exp_q[k].data), "entry data");
         compare(64'(seen_len[k]), 64'(exp_q[k].count), "prefetched_length");
         sum = sum + int'(seen_entry[k].count);
      end
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      fetch_case_t rnd;
      int          sum;
      int          off16;
      int          rnd_len;

      err_count             = 0;
      seed                  = 64869;
      clk                   = 1'b0;
      rst_n                 = 1'b0;
      pr_reset              = 1'b0;
      fetch_do              = 1'b0;
      fetch_req             = '0;
      readcode_done         = 1'b0;
      readcode_partial_done = 1'b0;
      readcode_partial      = '0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      compare(64'(readcode_do), 64'd0, "readcode_do after reset");
      compare(64'(prefetch_write_do), 64'd0, "prefetch_write_do after reset");
      compare(64'(prefetched_do), 64'd0, "prefetched_do after reset");

      for (int i = 0; i < $size(case_table); i++) begin
         run_case(case_table[i], 1'b1, sum);
      end

      // Random offsets and lengths up to the line end
      for (int r = 0; r < 48; r++) begin
         off16          = int'({$random(seed)} % 32'd16);
         rnd_len        = 1 + int'({$random(seed)} % 32'(16 - off16));
         rnd.address    = ($random(seed) & 32'hffff_fff0) | 32'(off16);
         rnd.length     = LEN_W'(rnd_len);
         rnd.flush_req  = 1'b0;
         rnd.flush_beat = '0;
         rnd.writes     = '0;
         run_case(rnd, 1'b0, sum);
         compare(64'(sum), 64'(rnd_len), "sum of entry counts against length");
      end

      if (err_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+tests
rtl/fetch_pkg.sv
rtl/beat_planner.sv
rtl/beat_aligner.sv
rtl/fetch_sequencer.sv
rtl/code_fetch_top.sv
tests/tb_code_fetch.sv

// ==== run.sh ====
#!/bin/sh
# Build the code fetch path with its testbench and run it under Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_code_fetch \
   -f build.f -o sim_code_fetch \
   && ./obj_dir/sim_code_fetch > sim.log 2>&1 \
   || echo "Build or simulation stopped with an error" >> sim.log

cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAILED"; exit 1; }
grep -q "All tests passed" sim.log && echo "PASSED" || { echo "FAILED"; exit 1; }
